/* Makefile */
TOP := tb_axi_read_xbar

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f axi_read_xbar.f --top-module axi_read_xbar

sim:
	verilator --binary --timing --assert -f axi_read_xbar.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin > sim.log 2>&1 || true
	cat sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* ai_dispatcher.sv */
module ai_dispatcher (
    input  logic                                 aclk_i,
    input  logic                                 reset_i,
    // Master AR and R
    input  axi_xbar_pkg::mst_id_t                m_arid_i,
    input  axi_xbar_pkg::addr_t                  m_araddr_i,
    input  axi_xbar_pkg::len_t                   m_arlen_i,
    input  logic                                 m_arvalid_i,
    input  logic                                 m_rready_i,
    output logic                                 m_arready_o,
    output axi_xbar_pkg::mst_id_t                m_rid_o,
    output axi_xbar_pkg::data_t                  m_rdata_o,
    output axi_xbar_pkg::resp_t                  m_rresp_o,
    output logic                                 m_rlast_o,
    output logic                                 m_rvalid_o,
    // Slave arbiters
    output logic [axi_xbar_pkg::SLV_AMT-1:0]     sa_arvalid_o,
    input  logic [axi_xbar_pkg::SLV_AMT-1:0]     sa_arready_i,
    input  axi_xbar_pkg::mst_id_t                sa_rid_i [axi_xbar_pkg::SLV_AMT],
    input  axi_xbar_pkg::data_t                  sa_rdata_i [axi_xbar_pkg::SLV_AMT],
    input  axi_xbar_pkg::resp_t                  sa_rresp_i [axi_xbar_pkg::SLV_AMT],
    input  logic [axi_xbar_pkg::SLV_AMT-1:0]     sa_rlast_i,
    input  logic [axi_xbar_pkg::SLV_AMT-1:0]     sa_rvalid_i,
    output logic [axi_xbar_pkg::SLV_AMT-1:0]     sa_rready_o
);
    import axi_xbar_pkg::*;

    outst_t   outst_cnt_q;
    slv_sel_t outst_slv_q;
    slv_sel_t ar_slv;
    logic     ar_allow;
    logic     ar_hs;
    logic     r_done;

    assign ar_slv = m_araddr_i[SLV_SEL_BIT];

    // New read only below the limit and only to the slave already in use
    assign ar_allow = (outst_cnt_q != outst_t'(OUTST_MAX)) &&
                      ((outst_cnt_q == '0) || (outst_slv_q == ar_slv));

    always_comb begin
        for (int s = 0; s < SLV_AMT; s++) begin
            sa_arvalid_o[s] = m_arvalid_i && ar_allow && (ar_slv == slv_sel_t'(s));
            sa_rready_o[s]  = m_rready_i && (outst_slv_q == slv_sel_t'(s));
        end
    end

    assign m_arready_o = ar_allow && sa_arready_i[ar_slv];
    assign ar_hs       = m_arvalid_i && m_arready_o;

    // Return path follows the tracked slave
    assign m_rvalid_o = sa_rvalid_i[outst_slv_q];
    assign m_rid_o    = sa_rid_i[outst_slv_q];
    assign m_rdata_o  = sa_rdata_i[outst_slv_q];
    assign m_rresp_o  = sa_rresp_i[outst_slv_q];
    assign m_rlast_o  = sa_rlast_i[outst_slv_q];

    assign r_done = m_rvalid_o && m_rready_i && m_rlast_o;

    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            outst_cnt_q <= '0;
            outst_slv_q <= '0;
        end else begin
            if (ar_hs && !r_done) begin
                outst_cnt_q <= outst_cnt_q + 1'b1;
            end else if (!ar_hs && r_done) begin
                outst_cnt_q <= outst_cnt_q - 1'b1;
            end
            if (ar_hs) begin
                outst_slv_q <= ar_slv;
            end
        end
    end

    // Limit holds across any mix of AR and R traffic
    assert property (@(posedge aclk_i) disable iff (reset_i)
        outst_cnt_q <= outst_t'(OUTST_MAX));

    // Arbiters only steer data to a master that has a read open
    assert property (@(posedge aclk_i) disable iff (reset_i)
        m_rvalid_o |-> (outst_cnt_q != '0));

    // Master keeps its request steady until taken
    assert property (@(posedge aclk_i) disable iff (reset_i)
        (m_arvalid_i && !m_arready_o) |=>
            (m_arvalid_i && $stable(m_arid_i) && $stable(m_araddr_i) &&
             $stable(m_arlen_i)));

endmodule

/* ai_slave_arbiter.sv */
module ai_slave_arbiter (
    input  logic                                 aclk_i,
    input  logic                                 reset_i,
    // Dispatchers
    input  logic [axi_xbar_pkg::MST_AMT-1:0]     dsp_arvalid_i,
    input  axi_xbar_pkg::mst_id_t                dsp_arid_i [axi_xbar_pkg::MST_AMT],
    input  axi_xbar_pkg::addr_t                  dsp_araddr_i [axi_xbar_pkg::MST_AMT],
    input  axi_xbar_pkg::len_t                   dsp_arlen_i [axi_xbar_pkg::MST_AMT],
    input  logic [axi_xbar_pkg::MST_AMT-1:0]     dsp_rready_i,
    output logic [axi_xbar_pkg::MST_AMT-1:0]     dsp_arready_o,
    output axi_xbar_pkg::mst_id_t                dsp_rid_o,
    output axi_xbar_pkg::data_t                  dsp_rdata_o,
    output axi_xbar_pkg::resp_t                  dsp_rresp_o,
    output logic                                 dsp_rlast_o,
    output logic [axi_xbar_pkg::MST_AMT-1:0]     dsp_rvalid_o,
    // Slave
    output axi_xbar_pkg::slv_id_t                s_arid_o,
    output axi_xbar_pkg::addr_t                  s_araddr_o,
    output axi_xbar_pkg::len_t                   s_arlen_o,
    output logic                                 s_arvalid_o,
    output logic                                 s_rready_o,
    input  logic                                 s_arready_i,
    input  axi_xbar_pkg::slv_id_t                s_rid_i,
    input  axi_xbar_pkg::data_t                  s_rdata_i,
    input  axi_xbar_pkg::resp_t                  s_rresp_i,
    input  logic                                 s_rlast_i,
    input  logic                                 s_rvalid_i
);
    import axi_xbar_pkg::*;

    logic [MST_AMT-1:0] grant;
    mst_sel_t           gnt_idx;
    mst_sel_t           r_mst;
    logic               stage_take;
    logic               stage_load;

    ai_wrr_grant u_wrr_grant (
        .aclk_i   (aclk_i),
        .reset_i  (reset_i),
        .req_i    (dsp_arvalid_i),
        .accept_i (stage_load),
        .grant_o  (grant)
    );

    // Stage takes a new request when empty or draining this cycle
    assign stage_take    = !s_arvalid_o || s_arready_i;
    assign stage_load    = stage_take && (|grant);
    assign dsp_arready_o = stage_take ? grant : '0;

    always_comb begin
        gnt_idx = '0;
        for (int m = 0; m < MST_AMT; m++) begin
            if (grant[m]) begin
                gnt_idx = mst_sel_t'(m);
            end
        end
    end

    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            s_arvalid_o <= 1'b0;
        end else if (stage_take) begin
            s_arvalid_o <= stage_load;
        end
    end

    // Master index goes on top of the master's ID
    always_ff @(posedge aclk_i) begin
        if (stage_load) begin
            s_arid_o   <= {gnt_idx, dsp_arid_i[gnt_idx]};
            s_araddr_o <= dsp_araddr_i[gnt_idx];
            s_arlen_o  <= dsp_arlen_i[gnt_idx];
        end
    end

    // R goes back to the master named in the top ID bit
    assign r_mst       = s_rid_i[SLV_ID_W-1];
    assign dsp_rid_o   = s_rid_i[MST_ID_W-1:0];
    assign dsp_rdata_o = s_rdata_i;
    assign dsp_rresp_o = s_rresp_i;
    assign dsp_rlast_o = s_rlast_i;
    assign s_rready_o  = dsp_rready_i[r_mst];

    always_comb begin
        for (int m = 0; m < MST_AMT; m++) begin
            dsp_rvalid_o[m] = s_rvalid_i && (r_mst == mst_sel_t'(m));
        end
    end

    // Request to the slave holds while stalled
    assert property (@(posedge aclk_i) disable iff (reset_i)
        (s_arvalid_o && !s_arready_i) |=>
            (s_arvalid_o && $stable(s_arid_o) && $stable(s_araddr_o) &&
             $stable(s_arlen_o)));

endmodule

/* ai_wrr_grant.sv */
module ai_wrr_grant (
    input  logic                              aclk_i,
    input  logic                              reset_i,
    input  logic [axi_xbar_pkg::MST_AMT-1:0]  req_i,
    input  logic                              accept_i,
    output logic [axi_xbar_pkg::MST_AMT-1:0]  grant_o
);
    import axi_xbar_pkg::*;

    mst_sel_t ptr_q;
    mst_sel_t ptr_nxt;
    mst_sel_t oth;
    credit_t  credit_q;
    credit_t  credit_nxt;

    function automatic credit_t weight_of(mst_sel_t mst);
        return mst ? credit_t'(MST_WEIGHT1) : credit_t'(MST_WEIGHT0);
    endfunction

    assign oth = ~ptr_q;

    always_comb begin
        grant_o    = '0;
        ptr_nxt    = ptr_q;
        credit_nxt = credit_q;
        if (req_i[ptr_q] && (credit_q != '0)) begin
            // Current master still has credit
            grant_o[ptr_q] = 1'b1;
            credit_nxt     = credit_q - 1'b1;
        end else if (req_i[oth]) begin
            grant_o[oth] = 1'b1;
            ptr_nxt      = oth;
            credit_nxt   = weight_of(oth) - 1'b1;
        end else if (req_i[ptr_q]) begin
            // Out of credit but alone, so start a fresh turn
            grant_o[ptr_q] = 1'b1;
            credit_nxt     = weight_of(ptr_q) - 1'b1;
        end
    end

    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            ptr_q    <= '0;
            credit_q <= credit_t'(MST_WEIGHT0);
        end else if (accept_i) begin
            ptr_q    <= ptr_nxt;
            credit_q <= credit_nxt;
        end
    end

    assert property (@(posedge aclk_i) disable iff (reset_i)
        $onehot0(grant_o));

endmodule

/* axi_read_xbar.f */
axi_xbar_pkg.sv
ai_wrr_grant.sv
ai_dispatcher.sv
ai_slave_arbiter.sv
axi_read_xbar.sv
tb_axi_read_xbar.sv

/* axi_read_xbar.sv */
module axi_read_xbar (
    input  logic                                 aclk_i,
    input  logic                                 reset_i,
    // Masters
    input  axi_xbar_pkg::mst_id_t                m_arid_i [axi_xbar_pkg::MST_AMT],
    input  axi_xbar_pkg::addr_t                  m_araddr_i [axi_xbar_pkg::MST_AMT],
    input  axi_xbar_pkg::len_t                   m_arlen_i [axi_xbar_pkg::MST_AMT],
    input  logic [axi_xbar_pkg::MST_AMT-1:0]     m_arvalid_i,
    output logic [axi_xbar_pkg::MST_AMT-1:0]     m_arready_o,
    output axi_xbar_pkg::mst_id_t                m_rid_o [axi_xbar_pkg::MST_AMT],
    output axi_xbar_pkg::data_t                  m_rdata_o [axi_xbar_pkg::MST_AMT],
    output axi_xbar_pkg::resp_t                  m_rresp_o [axi_xbar_pkg::MST_AMT],
    output logic [axi_xbar_pkg::MST_AMT-1:0]     m_rlast_o,
    output logic [axi_xbar_pkg::MST_AMT-1:0]     m_rvalid_o,
    input  logic [axi_xbar_pkg::MST_AMT-1:0]     m_rready_i,
    // Slaves
    output axi_xbar_pkg::slv_id_t                s_arid_o [axi_xbar_pkg::SLV_AMT],
    output axi_xbar_pkg::addr_t                  s_araddr_o [axi_xbar_pkg::SLV_AMT],
    output axi_xbar_pkg::len_t                   s_arlen_o [axi_xbar_pkg::SLV_AMT],
    output logic [axi_xbar_pkg::SLV_AMT-1:0]     s_arvalid_o,
    input  logic [axi_xbar_pkg::SLV_AMT-1:0]     s_arready_i,
    input  axi_xbar_pkg::slv_id_t                s_rid_i [axi_xbar_pkg::SLV_AMT],
    input  axi_xbar_pkg::data_t                  s_rdata_i [axi_xbar_pkg::SLV_AMT],
    input  axi_xbar_pkg::resp_t                  s_rresp_i [axi_xbar_pkg::SLV_AMT],
    input  logic [axi_xbar_pkg::SLV_AMT-1:0]     s_rlast_i,
    input  logic [axi_xbar_pkg::SLV_AMT-1:0]     s_rvalid_i,
    output logic [axi_xbar_pkg::SLV_AMT-1:0]     s_rready_o
);
    import axi_xbar_pkg::*;

    // Dispatcher side indexed by [master][slave]
    logic [SLV_AMT-1:0] dsp_arvalid [MST_AMT];
    logic [SLV_AMT-1:0] dsp_arready [MST_AMT];
    logic [SLV_AMT-1:0] dsp_rvalid  [MST_AMT];
    logic [SLV_AMT-1:0] dsp_rready  [MST_AMT];
    // Arbiter side indexed by [slave][master]
    logic [MST_AMT-1:0] sa_arvalid  [SLV_AMT];
    logic [MST_AMT-1:0] sa_arready  [SLV_AMT];
    logic [MST_AMT-1:0] sa_rvalid   [SLV_AMT];
    logic [MST_AMT-1:0] sa_rready   [SLV_AMT];
    // R payload seen by every dispatcher
    mst_id_t            sa_rid      [SLV_AMT];
    data_t              sa_rdata    [SLV_AMT];
    resp_t              sa_rresp    [SLV_AMT];
    logic [SLV_AMT-1:0] sa_rlast;

    always_comb begin
        for (int m = 0; m < MST_AMT; m++) begin
            for (int s = 0; s < SLV_AMT; s++) begin
                sa_arvalid[s][m]  = dsp_arvalid[m][s];
                dsp_arready[m][s] = sa_arready[s][m];
                dsp_rvalid[m][s]  = sa_rvalid[s][m];
                sa_rready[s][m]   = dsp_rready[m][s];
            end
        end
    end

    for (genvar m = 0; m < MST_AMT; m++) begin : g_mst
        ai_dispatcher u_dispatcher (
            .aclk_i       (aclk_i),
            .reset_i      (reset_i),
            .m_arid_i     (m_arid_i[m]),
            .m_araddr_i   (m_araddr_i[m]),
            .m_arlen_i    (m_arlen_i[m]),
            .m_arvalid_i  (m_arvalid_i[m]),
            .m_rready_i   (m_rready_i[m]),
            .m_arready_o  (m_arready_o[m]),
            .m_rid_o      (m_rid_o[m]),
            .m_rdata_o    (m_rdata_o[m]),
            .m_rresp_o    (m_rresp_o[m]),
            .m_rlast_o    (m_rlast_o[m]),
            .m_rvalid_o   (m_rvalid_o[m]),
            .sa_arvalid_o (dsp_arvalid[m]),
            .sa_arready_i (dsp_arready[m]),
            .sa_rid_i     (sa_rid),
            .sa_rdata_i   (sa_rdata),
            .sa_rresp_i   (sa_rresp),
            .sa_rlast_i   (sa_rlast),
            .sa_rvalid_i  (dsp_rvalid[m]),
            .sa_rready_o  (dsp_rready[m])
        );
    end

    // AR payload goes straight from the masters while valid is decoded
    for (genvar s = 0; s < SLV_AMT; s++) begin : g_slv
        ai_slave_arbiter u_slave_arbiter (
            .aclk_i        (aclk_i),
            .reset_i       (reset_i),
            .dsp_arvalid_i (sa_arvalid[s]),
            .dsp_arid_i    (m_arid_i),
            .dsp_araddr_i  (m_araddr_i),
            .dsp_arlen_i   (m_arlen_i),
            .dsp_rready_i  (sa_rready[s]),
            .dsp_arready_o (sa_arready[s]),
            .dsp_rid_o     (sa_rid[s]),
            .dsp_rdata_o   (sa_rdata[s]),
            .dsp_rresp_o   (sa_rresp[s]),
            .dsp_rlast_o   (sa_rlast[s]),
            .dsp_rvalid_o  (sa_rvalid[s]),
            .s_arid_o      (s_arid_o[s]),
            .s_araddr_o    (s_araddr_o[s]),
            .s_arlen_o     (s_arlen_o[s]),
            .s_arvalid_o   (s_arvalid_o[s]),
            .s_rready_o    (s_rready_o[s]),
            .s_arready_i   (s_arready_i[s]),
            .s_rid_i       (s_rid_i[s]),
            .s_rdata_i     (s_rdata_i[s]),
            .s_rresp_i     (s_rresp_i[s]),
            .s_rlast_i     (s_rlast_i[s]),
            .s_rvalid_i    (s_rvalid_i[s])
        );
    end

endmodule

/* axi_xbar_pkg.sv */
package axi_xbar_pkg;

    // Crossbar size
    localparam int MST_AMT = 2;
    localparam int SLV_AMT = 2;

    // Channel widths
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int MST_ID_W = 4;
    // Master index sits above the master's own ID
    localparam int SLV_ID_W = MST_ID_W + $clog2(MST_AMT);
    localparam int LEN_W    = 3;
    localparam int RESP_W   = 2;

    // Reads in flight per master
    localparam int OUTST_MAX = 4;

    // Arbitration weights in grants per turn
    localparam int MST_WEIGHT0 = 3;
    localparam int MST_WEIGHT1 = 1;

    // Top address bit picks the slave
    localparam int SLV_SEL_BIT = ADDR_W - 1;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [MST_ID_W-1:0] mst_id_t;
    typedef logic [SLV_ID_W-1:0] slv_id_t;
    typedef logic [LEN_W-1:0]    len_t;
    typedef logic [RESP_W-1:0]   resp_t;
    typedef logic                mst_sel_t;
    typedef logic                slv_sel_t;
    typedef logic [1:0]          credit_t;
    typedef logic [2:0]          outst_t;

endpackage

/* tb_axi_read_xbar.sv */
module tb_axi_read_xbar;
    import axi_xbar_pkg::*;

    // Reset plus the five tests with room for random stalls
    localparam int CYCLE_LIMIT = 16 + 60 + 120 + 200 + 400 + 300;

    logic               aclk_i;
    logic               reset_i;
    mst_id_t            m_arid [MST_AMT];
    addr_t              m_araddr [MST_AMT];
    len_t               m_arlen [MST_AMT];
    logic [MST_AMT-1:0] m_arvalid;
    logic [MST_AMT-1:0] m_arready;
    mst_id_t            m_rid [MST_AMT];
    data_t              m_rdata [MST_AMT];
    resp_t              m_rresp [MST_AMT];
    logic [MST_AMT-1:0] m_rlast;
    logic [MST_AMT-1:0] m_rvalid;
    logic [MST_AMT-1:0] m_rready = '1;
    slv_id_t            s_arid [SLV_AMT];
    addr_t              s_araddr [SLV_AMT];
    len_t               s_arlen [SLV_AMT];
    logic [SLV_AMT-1:0] s_arvalid;
    logic [SLV_AMT-1:0] s_arready = '0;
    slv_id_t            s_rid [SLV_AMT] = '{default: '0};
    data_t              s_rdata [SLV_AMT] = '{default: '0};
    resp_t              s_rresp [SLV_AMT] = '{default: '0};
    logic [SLV_AMT-1:0] s_rlast = '0;
    logic [SLV_AMT-1:0] s_rvalid = '0;
    logic [SLV_AMT-1:0] s_rready;

    int          cyc = 0;
    logic [31:0] rng = 32'he89a5ed8;
    // Slave AR mode 0 is random, 1 always ready and 2 never ready
    logic [1:0]         ar_mode [SLV_AMT] = '{default: '0};
    logic [SLV_AMT-1:0] rsp_en = '1;
    logic [MST_AMT-1:0] rready_rnd = '0;
    logic               grant_log [$];
    logic [39:0]        ar_q [SLV_AMT][$];
    int                 beat [SLV_AMT] = '{default: 0};
    logic [MST_AMT-1:0] pend = '0;
    data_t              held [MST_AMT];

    axi_read_xbar u_dut (
        .aclk_i      (aclk_i),
        .reset_i     (reset_i),
        .m_arid_i    (m_arid),
        .m_araddr_i  (m_araddr),
        .m_arlen_i   (m_arlen),
        .m_arvalid_i (m_arvalid),
        .m_arready_o (m_arready),
        .m_rid_o     (m_rid),
        .m_rdata_o   (m_rdata),
        .m_rresp_o   (m_rresp),
        .m_rlast_o   (m_rlast),
        .m_rvalid_o  (m_rvalid),
        .m_rready_i  (m_rready),
        .s_arid_o    (s_arid),
        .s_araddr_o  (s_araddr),
        .s_arlen_o   (s_arlen),
        .s_arvalid_o (s_arvalid),
        .s_arready_i (s_arready),
        .s_rid_i     (s_rid),
        .s_rdata_i   (s_rdata),
        .s_rresp_i   (s_rresp),
        .s_rlast_i   (s_rlast),
        .s_rvalid_i  (s_rvalid),
        .s_rready_o  (s_rready)
    );

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic stop_run(string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] expv);
        assert (got === expv) else
            stop_run($sformatf("FAILED %s: got %h, expected %h", name, got, expv));
    endtask

    initial begin
        aclk_i = 1'b0;
        forever #20 aclk_i = ~aclk_i;
    end

    always @(posedge aclk_i) begin
        rng <= xorshift(rng);
        cyc <= cyc + 1;
        if (cyc > CYCLE_LIMIT) begin
            stop_run("Simulation timed out waiting for the DUT");
        end
    end

    always @(posedge aclk_i) begin
        for (int m = 0; m < MST_AMT; m++) begin
            m_rready[m] <= rready_rnd[m] ? rng[8+m] : 1'b1;
        end
    end

    // Slave models answer in order with one beat per cycle
    always @(posedge aclk_i) begin
        for (int s = 0; s < SLV_AMT; s++) begin
            if (reset_i) begin
                ar_q[s].delete();
                beat[s] = 0;
                s_arready[s] <= 1'b0;
                s_rvalid[s]  <= 1'b0;
            end else begin
                if (s_arvalid[s] && s_arready[s]) begin
                    ar_q[s].push_back({s_arid[s], s_araddr[s], s_arlen[s]});
                    if (s == 0) begin
                        grant_log.push_back(s_arid[s][SLV_ID_W-1]);
                    end
                end
                if (s_rvalid[s] && s_rready[s]) begin
                    beat[s]++;
                    if (beat[s] > int'(ar_q[s][0][2:0])) begin
                        void'(ar_q[s].pop_front());
                        beat[s] = 0;
                    end
                end
                case (ar_mode[s])
                    2'd1:    s_arready[s] <= 1'b1;
                    2'd2:    s_arready[s] <= 1'b0;
                    default: s_arready[s] <= |rng[2*s +: 2];
                endcase
                if (rsp_en[s] && ar_q[s].size() > 0) begin
                    s_rvalid[s] <= 1'b1;
                    s_rid[s]    <= ar_q[s][0][39:35];
                    s_rdata[s]  <= (ar_q[s][0][34:3] ^ 32'h5a5a0000) + 32'(beat[s]);
                    s_rlast[s]  <= (beat[s] == int'(ar_q[s][0][2:0]));
                end else begin
                    s_rvalid[s] <= 1'b0;
                end
            end
        end
    end

    // R payload must hold while the master stalls
    always @(posedge aclk_i) begin
        for (int m = 0; m < MST_AMT; m++) begin
            if (!reset_i && pend[m]) begin
                assert (m_rvalid[m]) else stop_run("m_rvalid dropped before it was accepted");
                check_val("m_rdata held", m_rdata[m], held[m]);
            end
            pend[m] = m_rvalid[m] && !m_rready[m];
            held[m] = m_rdata[m];
        end
    end

    task automatic issue_reads(int m, int n, mst_id_t id0, addr_t addr0, len_t len,
                               output int hs_cyc);
        @(posedge aclk_i);
        for (int i = 0; i < n; i++) begin
            m_arvalid[m] <= 1'b1;
            m_arid[m]    <= id0 + mst_id_t'(i);
            m_araddr[m]  <= addr0 + addr_t'(i * 32);
            m_arlen[m]   <= len;
            do @(posedge aclk_i); while (!m_arready[m]);
        end
        hs_cyc = cyc;
        m_arvalid[m] <= 1'b0;
    endtask

    task automatic collect_reads(int m, int n, mst_id_t id0, addr_t addr0, len_t len,
                                 output int last_cyc);
        addr_t addr;
        for (int i = 0; i < n; i++) begin
            addr = addr0 + addr_t'(i * 32);
            for (int k = 0; k <= int'(len); k++) begin
                do @(posedge aclk_i); while (!(m_rvalid[m] && m_rready[m]));
                check_val("m_rid", 32'(m_rid[m]), 32'(id0 + mst_id_t'(i)));
                check_val("m_rdata", m_rdata[m], (addr ^ 32'h5a5a0000) + 32'(k));
                check_val("m_rresp", 32'(m_rresp[m]), 32'h0);
                check_val("m_rlast", 32'(m_rlast[m]), 32'(k == int'(len)));
            end
        end
        last_cyc = cyc;
    endtask

    task automatic read_routed(int m, mst_id_t id, addr_t addr, len_t len);
        int   hs;
        int   lc;
        int   sel;
        sel = int'(addr[SLV_SEL_BIT]);
        issue_reads(m, 1, id, addr, len, hs);
        @(posedge aclk_i);
        check_val("s_arvalid selected", 32'(s_arvalid[sel]), 32'h1);
        check_val("s_arvalid other", 32'(s_arvalid[1-sel]), 32'h0);
        check_val("s_arid", 32'(s_arid[sel]), 32'({m[0], id}));
        check_val("s_araddr", s_araddr[sel], addr);
        check_val("s_arlen", 32'(s_arlen[sel]), 32'(len));
        collect_reads(m, 1, id, addr, len, lc);
    endtask

    task automatic single_read();
        check_val("s_arvalid", 32'(s_arvalid), 32'h0);
        check_val("m_rvalid", 32'(m_rvalid), 32'h0);
        read_routed(0, 4'h3, 32'h0000_0100, 3'd3);
    endtask

    task automatic decode_and_id();
        read_routed(1, 4'h9, 32'h8000_0040, 3'd1);
        read_routed(1, 4'ha, 32'h0000_0040, 3'd2);
    endtask

    task automatic weighted_grants();
        int h0;
        int h1;
        int l0;
        int l1;
        ar_mode[0] = 2'd1;
        grant_log.delete();
        fork
            issue_reads(0, 9, 4'h0, 32'h0000_1000, 3'd0, h0);
            issue_reads(1, 3, 4'h0, 32'h0000_2000, 3'd0, h1);
            collect_reads(0, 9, 4'h0, 32'h0000_1000, 3'd0, l0);
            collect_reads(1, 3, 4'h0, 32'h0000_2000, 3'd0, l1);
        join
        check_val("grant count", 32'(grant_log.size()), 32'd12);
        for (int i = 0; i < 12; i++) begin
            check_val("s_arid master bit", 32'(grant_log[i]), 32'(i % 4 == 3));
        end
        ar_mode[0] = 2'd0;
    endtask

    task automatic stall_hold();
        int      h;
        int      l;
        int      blocked;
        slv_id_t id_q;
        addr_t   addr_q;
        rready_rnd = '1;
        fork
            begin
                issue_reads(0, 2, 4'h5, 32'h0000_0300, 3'd7, h);
                collect_reads(0, 2, 4'h5, 32'h0000_0300, 3'd7, l);
            end
            begin
                issue_reads(1, 2, 4'h6, 32'h8000_0300, 3'd5, h);
                collect_reads(1, 2, 4'h6, 32'h8000_0300, 3'd5, l);
            end
        join
        ar_mode[1] = 2'd2;
        blocked = 0;
        fork
            begin
                issue_reads(1, 1, 4'h7, 32'h8000_0400, 3'd2, h);
                collect_reads(1, 1, 4'h7, 32'h8000_0400, 3'd2, l);
            end
            begin
                repeat (2) @(posedge aclk_i);
                issue_reads(0, 1, 4'h8, 32'h8000_0500, 3'd2, h);
                collect_reads(0, 1, 4'h8, 32'h8000_0500, 3'd2, l);
            end
            begin
                do @(posedge aclk_i); while (!(s_arvalid[1] && !s_arready[1]));
                id_q   = s_arid[1];
                addr_q = s_araddr[1];
                repeat (6) begin
                    @(posedge aclk_i);
                    check_val("s_arvalid stalled", 32'(s_arvalid[1]), 32'h1);
                    check_val("s_arid stalled", 32'(s_arid[1]), 32'(id_q));
                    check_val("s_araddr stalled", s_araddr[1], addr_q);
                    for (int m = 0; m < MST_AMT; m++) begin
                        if (m_arvalid[m]) begin
                            check_val("m_arready blocked", 32'(m_arready[m]), 32'h0);
                            blocked++;
                        end
                    end
                end
                assert (blocked > 0) else stop_run("No master was blocked by the stall");
                ar_mode[1] = 2'd0;
            end
        join
        rready_rnd = '0;
    endtask

    task automatic order_and_limit();
        int h;
        int h2;
        int lc;
        int l;
        fork
            begin
                issue_reads(0, 1, 4'h1, 32'h0000_0600, 3'd7, h);
                issue_reads(0, 1, 4'h2, 32'h8000_0600, 3'd0, h2);
            end
            begin
                collect_reads(0, 1, 4'h1, 32'h0000_0600, 3'd7, lc);
                collect_reads(0, 1, 4'h2, 32'h8000_0600, 3'd0, l);
            end
        join
        assert (h2 > lc) else stop_run("Read to the other slave was accepted too early");
        // Slave 1 holds back its data until the fifth request has waited
        rsp_en[1]  = 1'b0;
        ar_mode[1] = 2'd1;
        issue_reads(1, 4, 4'h0, 32'h8000_0700, 3'd1, h);
        fork
            issue_reads(1, 1, 4'h4, 32'h8000_0780, 3'd1, h2);
            begin
                repeat (8) begin
                    @(posedge aclk_i);
                    check_val("m_arready at limit", 32'(m_arready[1]), 32'h0);
                end
                rsp_en[1] = 1'b1;
                collect_reads(1, 4, 4'h0, 32'h8000_0700, 3'd1, l);
                collect_reads(1, 1, 4'h4, 32'h8000_0780, 3'd1, l);
            end
        join
        ar_mode[1] = 2'd0;
    endtask

    initial begin
        reset_i   = 1'b1;
        m_arvalid = '0;
        m_arid    = '{default: '0};
        m_araddr  = '{default: '0};
        m_arlen   = '{default: '0};
        repeat (16) @(posedge aclk_i);
        reset_i <= 1'b0;
        @(posedge aclk_i);
        single_read();
        decode_and_id();
        weighted_grants();
        stall_hold();
        order_and_limit();
        $display("all tests passed");
        $finish;
    end

endmodule
